// File: common/decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

`define WORD_W 32 // program word and datum
`define REG_ADDR_W 5 // register number
`define OPCODE_W 7
`define COND_W 4
`define FLAGS_W 4 // flag write mask
`define ALU_OP_W 8
`define MEM_OP_W 4
`define WB_OP_W 4

`define BRANCH_DELAY 3 // words skipped after a branch
`define REG_PC 31
`define REG_LR 29

`define OPC_MSB 31 // instruction word layout
`define OPC_LSB 25
`define COND_MSB 24
`define COND_LSB 21
`define FA_MSB 20
`define FA_LSB 16
`define FB_MSB 15
`define FB_LSB 11
`define FC_MSB 10
`define FC_LSB 6
`define FD_MSB 5
`define FD_LSB 1
`define IMM_MSB 5 // overlaps field d
`define IMM_LSB 4

`endif

// File: common/decoder_pkg.sv
`include "decoder_settings.svh"

package decoder_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`COND_W-1:0] cond_t;
	typedef logic [`FLAGS_W-1:0] flags_t;
	typedef logic [1:0] read_mask_t; // bit0 first port, bit1 second

	typedef enum logic [`OPCODE_W-1:0] {
		OP_NOP = 0, OP_OR, OP_NOR, OP_AND, OP_NAND, OP_INV, OP_XOR, OP_XNOR, // logic
		OP_LSL, OP_LSR, OP_ASR, OP_ASL, OP_CSR, OP_CSL, // shifts, rotates
		OP_ADD, OP_SUB, OP_MULL, OP_MULH, OP_MUL, OP_CSG, OP_INC, OP_DEC,
		OP_CMP, OP_CMN, OP_TST,
		OP_BR, OP_RBR, OP_BRL, OP_RET, // branches
		OP_LDR, OP_STR, OP_IN, OP_OUT, // memory and system
		OP_MOVS, OP_MOV
	} opcode_e;

	typedef enum logic [`ALU_OP_W-1:0] {
		ALU_NOP = 'h00,
		ALU_ADD = 'h01,
		ALU_SUB = 'h02,
		ALU_CPL = 'h03, // sign change
		ALU_MUL = 'h04,
		ALU_SHR = 'h05,
		ALU_SHL = 'h06,
		ALU_SAR = 'h07,
		ALU_SAL = 'h08,
		ALU_ROR = 'h09,
		ALU_ROL = 'h0A,
		ALU_NOT = 'h0B,
		ALU_AND = 'h0C,
		ALU_OR = 'h0D,
		ALU_XOR = 'h0E,
		ALU_NAND = 'h0F,
		ALU_NOR = 'h10,
		ALU_XNOR = 'h11
	} alu_op_e;

	typedef enum logic [`MEM_OP_W-1:0] {
		MEM_NONE = 'h0,
		MEM_PASS = 'h1, // result passes through
		MEM_READ = 'h2,
		MEM_WRITE = 'h5,
		MEM_SYS_READ = 'h8,
		MEM_SYS_WRITE = 'hB
	} mem_op_e;

	typedef enum logic [`WB_OP_W-1:0] {
		WB_NONE = 'h0,
		WB_FIRST = 'h1, // a1 only
		WB_HIGH = 'h4, // upper product half to a1
		WB_BOTH = 'h7
	} wb_op_e;

	// low two bits are the word's immediate action, bit2 steers to memory
	typedef enum logic [2:0] {
		IMM_NONE = 3'b000,
		IMM_B = 3'b001,
		IMM_A = 3'b010,
		IMM_AB = 3'b011, // a first, then b
		IMM_M1 = 3'b101,
		IMM_M2 = 3'b110,
		IMM_M21 = 3'b111 // m_a2 first, then m_a1
	} imm_op_e;

	typedef enum logic [1:0] {
		SEQ_DECODE,
		SEQ_IMM,
		SEQ_DELAY
	} seq_state_e;

endpackage

// File: decode/opcode_table.sv
`timescale 1ns/1ps
`include "decoder_settings.svh"

module opcode_table import decoder_pkg::*; (
	input word_t word,
	output alu_op_e alu_op,
	output cond_t cond,
	output flags_t write_flags,
	output logic is_cond,
	output mem_op_e m_r1_op,
	output mem_op_e m_r2_op,
	output wb_op_e r_op,
	output reg_addr_t r_a1,
	output reg_addr_t r_a2,
	output reg_addr_t rd1_addr,
	output reg_addr_t rd2_addr,
	output read_mask_t read_mask,
	output logic a_from_file,
	output logic b_from_file,
	output logic m1_from_file,
	output logic force_b_one,
	output imm_op_e imm_op,
	output logic is_branch,
	output logic legal
);

	logic [`OPCODE_W-1:0] op_raw;
	opcode_e op;
	reg_addr_t fa, fb, fc, fd;
	logic [1:0] act; // immediate action after masking
	logic mem_route; // r1 feeds m_a1 instead of e_a
	logic single; // reads field a only
	logic no_b_imm;
	logic no_imm;

	assign op_raw = word[`OPC_MSB:`OPC_LSB];
	assign op = opcode_e'(op_raw);
	assign fa = word[`FA_MSB:`FA_LSB];
	assign fb = word[`FB_MSB:`FB_LSB];
	assign fc = word[`FC_MSB:`FC_LSB];
	assign fd = word[`FD_MSB:`FD_LSB];
	assign legal = (op_raw <= OP_MOV); // 35..127 undefined

	always_comb begin
		alu_op = ALU_NOP; // defaults fit a register-form op
		cond = word[`COND_MSB:`COND_LSB];
		write_flags = (op_raw >= OP_OR && op_raw <= OP_TST) ? '1 : '0;
		is_cond = 1'b1;
		m_r1_op = MEM_PASS;
		m_r2_op = MEM_PASS;
		r_op = WB_FIRST;
		r_a1 = fc;
		r_a2 = '0;
		rd1_addr = fa;
		rd2_addr = fb;
		read_mask = 2'b11;
		mem_route = 1'b0;
		single = 1'b0;
		no_b_imm = 1'b0;
		no_imm = 1'b0;
		force_b_one = 1'b0;
		is_branch = 1'b0;
		case (op)
			OP_NOP: begin
				cond = '0; // bundle stays all zero
				is_cond = 1'b0;
				m_r1_op = MEM_NONE;
				m_r2_op = MEM_NONE;
				r_op = WB_NONE;
				r_a1 = '0;
				rd1_addr = '0;
				rd2_addr = '0;
				read_mask = 2'b00;
				no_imm = 1'b1;
			end
			OP_OR: alu_op = ALU_OR;
			OP_NOR: alu_op = ALU_NOR;
			OP_AND: alu_op = ALU_AND;
			OP_NAND: alu_op = ALU_NAND;
			OP_INV: begin
				alu_op = ALU_NOT;
				single = 1'b1;
			end
			OP_XOR: alu_op = ALU_XOR;
			OP_XNOR: alu_op = ALU_XNOR;
			OP_LSL: alu_op = ALU_SHL;
			OP_LSR: alu_op = ALU_SHR;
			OP_ASR: alu_op = ALU_SAR;
			OP_ASL: alu_op = ALU_SAL;
			OP_CSR: alu_op = ALU_ROR;
			OP_CSL: alu_op = ALU_ROL;
			OP_ADD: alu_op = ALU_ADD;
			OP_SUB: alu_op = ALU_SUB;
			OP_MULL: alu_op = ALU_MUL; // low half
			OP_MULH: begin
				alu_op = ALU_MUL;
				r_op = WB_HIGH;
			end
			OP_MUL: begin
				alu_op = ALU_MUL; // full product to c and d
				r_op = WB_BOTH;
				r_a2 = fd;
				no_imm = 1'b1; // d field holds a register
			end
			OP_CSG: begin
				alu_op = ALU_CPL;
				single = 1'b1;
			end
			OP_INC, OP_DEC: begin
				alu_op = (op == OP_INC) ? ALU_ADD : ALU_SUB;
				single = 1'b1;
				force_b_one = 1'b1;
			end
			OP_CMP, OP_CMN, OP_TST: begin
				alu_op = (op == OP_CMP) ? ALU_SUB : (op == OP_CMN) ? ALU_ADD : ALU_AND;
				r_op = WB_NONE; // flags only
				r_a1 = '0;
			end
			OP_BR: begin
				single = 1'b1; // target from a
				is_branch = 1'b1;
				r_a1 = reg_addr_t'(`REG_PC);
			end
			OP_RBR: begin
				alu_op = ALU_ADD; // pc + a
				is_branch = 1'b1;
				no_b_imm = 1'b1;
				r_a1 = reg_addr_t'(`REG_PC);
				rd1_addr = reg_addr_t'(`REG_PC);
				rd2_addr = fa;
			end
			OP_BRL: begin
				is_branch = 1'b1;
				no_b_imm = 1'b1;
				r_op = WB_BOTH; // old pc lands in lr
				r_a1 = reg_addr_t'(`REG_PC);
				r_a2 = reg_addr_t'(`REG_LR);
				rd2_addr = reg_addr_t'(`REG_PC);
			end
			OP_RET: begin
				single = 1'b1;
				is_branch = 1'b1;
				no_imm = 1'b1;
				r_a1 = reg_addr_t'(`REG_PC);
				rd1_addr = reg_addr_t'(`REG_LR);
			end
			OP_LDR, OP_IN: begin
				m_r1_op = (op == OP_LDR) ? MEM_READ : MEM_SYS_READ;
				mem_route = 1'b1;
				single = 1'b1;
			end
			OP_STR, OP_OUT: begin
				m_r2_op = (op == OP_STR) ? MEM_WRITE : MEM_SYS_WRITE; // data from b
				mem_route = 1'b1;
				r_op = WB_NONE;
				r_a1 = '0;
			end
			OP_MOVS: single = 1'b1;
			OP_MOV: begin
				r_op = WB_BOTH; // a,b to c,d
				r_a2 = fd;
				no_imm = 1'b1;
			end
			default: no_imm = 1'b1; // consumed as one word
		endcase
		if (single) begin
			read_mask = 2'b01;
			rd2_addr = '0;
		end
		act = word[`IMM_MSB:`IMM_LSB];
		if (single || no_b_imm)
			act[0] = 1'b0; // b never takes an immediate
		if (no_imm)
			act = 2'b00;
		imm_op = (act == 2'b00) ? IMM_NONE : imm_op_e'({mem_route, act});
		a_from_file = read_mask[0] && !mem_route;
		b_from_file = read_mask[1];
		m1_from_file = read_mask[0] && mem_route;
	end

endmodule

// File: decode/issue_sequencer.sv
`timescale 1ns/1ps
`include "decoder_settings.svh"

module issue_sequencer import decoder_pkg::*; (
	input logic rst, // clock
	input logic clk, // async active-high reset
	input alu_op_e alu_op,
	input cond_t cond,
	input flags_t write_flags,
	input logic is_cond,
	input mem_op_e mem1_op,
	input mem_op_e mem2_op,
	input wb_op_e wb_op,
	input reg_addr_t wb_a1,
	input reg_addr_t wb_a2,
	input reg_addr_t rd1_addr,
	input reg_addr_t rd2_addr,
	input read_mask_t read_mask,
	input imm_op_e imm_op,
	input logic is_branch,
	input logic legal,
	output alu_op_e e_alu_op,
	output cond_t e_cond,
	output flags_t e_write_flags,
	output logic e_is_cond,
	output mem_op_e m_r1_op,
	output mem_op_e m_r2_op,
	output wb_op_e r_op,
	output reg_addr_t r_a1,
	output reg_addr_t r_a2,
	output reg_addr_t r_r1_addr,
	output reg_addr_t r_r2_addr,
	output read_mask_t r_read,
	output logic issue_valid,
	output logic d_pcincr,
	output logic decode_en,
	output logic load_a,
	output logic load_b,
	output logic load_m1,
	output logic load_m2
);

	localparam int CNT_W = $clog2(`BRANCH_DELAY + 2); // holds 2 imms or delay-1

	seq_state_e state_q, state_d;
	logic [CNT_W-1:0] count_q, count_d; // imms or delay words left
	imm_op_e imm_q, imm_d; // steering of the next immediate
	logic branch_q, branch_d;
	logic issue_d;
	alu_op_e alu_q;
	cond_t cond_q;
	flags_t flags_q;
	logic is_cond_q;
	mem_op_e mem1_q, mem2_q;
	wb_op_e wb_q;
	reg_addr_t wb_a1_q, wb_a2_q, rd1_q, rd2_q;
	read_mask_t read_q;

	function automatic logic [CNT_W-1:0] imm_words(imm_op_e op);
		case (op)
			IMM_NONE: imm_words = '0;
			IMM_AB, IMM_M21: imm_words = CNT_W'(2);
			default: imm_words = CNT_W'(1);
		endcase
	endfunction

	assign decode_en = (state_q == SEQ_DECODE) && legal;
	assign load_a = (state_q == SEQ_IMM) && (imm_q == IMM_A || imm_q == IMM_AB);
	assign load_b = (state_q == SEQ_IMM) && (imm_q == IMM_B);
	assign load_m1 = (state_q == SEQ_IMM) && (imm_q == IMM_M1);
	assign load_m2 = (state_q == SEQ_IMM) && (imm_q == IMM_M2 || imm_q == IMM_M21);

	always_comb begin
		state_d = state_q;
		count_d = count_q;
		imm_d = imm_q;
		branch_d = branch_q;
		issue_d = 1'b0;
		case (state_q)
			SEQ_DECODE: if (legal) begin
				branch_d = is_branch;
				imm_d = imm_op;
				if (imm_op != IMM_NONE) begin
					state_d = SEQ_IMM;
					count_d = imm_words(imm_op);
				end else begin
					issue_d = 1'b1; // single-word insn
					if (is_branch) begin
						state_d = SEQ_DELAY;
						count_d = CNT_W'(`BRANCH_DELAY - 1);
					end
				end
			end
			SEQ_IMM: begin
				count_d = count_q - 1'b1;
				if (imm_q == IMM_AB)
					imm_d = IMM_B; // second word goes to b
				else if (imm_q == IMM_M21)
					imm_d = IMM_M1;
				if (count_q == CNT_W'(1)) begin
					issue_d = 1'b1; // last immediate
					state_d = branch_q ? SEQ_DELAY : SEQ_DECODE;
					if (branch_q)
						count_d = CNT_W'(`BRANCH_DELAY - 1);
				end
			end
			SEQ_DELAY: begin
				if (count_q == '0)
					state_d = SEQ_DECODE; // resume on next word
				else
					count_d = count_q - 1'b1;
			end
			default: state_d = SEQ_DECODE;
		endcase
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			state_q <= SEQ_DECODE;
			count_q <= '0;
			imm_q <= IMM_NONE;
			branch_q <= 1'b0;
			issue_valid <= 1'b0;
			d_pcincr <= 1'b0;
		end else begin
			state_q <= state_d;
			count_q <= count_d;
			imm_q <= imm_d;
			branch_q <= branch_d;
			issue_valid <= issue_d;
			d_pcincr <= (state_d != SEQ_DELAY); // no fetch in branch shadow
		end
	end

	// held from the opcode word until issue
	always_ff @(posedge rst) begin
		if (decode_en) begin
			alu_q <= alu_op;
			cond_q <= cond;
			flags_q <= write_flags;
			is_cond_q <= is_cond;
			mem1_q <= mem1_op;
			mem2_q <= mem2_op;
			wb_q <= wb_op;
			wb_a1_q <= wb_a1;
			wb_a2_q <= wb_a2;
			rd1_q <= rd1_addr;
			rd2_q <= rd2_addr;
			read_q <= read_mask;
		end
	end

	assign e_alu_op = issue_valid ? alu_q : ALU_NOP; // bubble is all zero
	assign e_cond = issue_valid ? cond_q : '0;
	assign e_write_flags = issue_valid ? flags_q : '0;
	assign e_is_cond = issue_valid && is_cond_q;
	assign m_r1_op = issue_valid ? mem1_q : MEM_NONE;
	assign m_r2_op = issue_valid ? mem2_q : MEM_NONE;
	assign r_op = issue_valid ? wb_q : WB_NONE;
	assign r_a1 = issue_valid ? wb_a1_q : '0;
	assign r_a2 = issue_valid ? wb_a2_q : '0;
	assign r_r1_addr = issue_valid ? rd1_q : '0;
	assign r_r2_addr = issue_valid ? rd2_q : '0;
	assign r_read = issue_valid ? read_q : '0;

	// strobes only while immediates remain
	a_load_only_pending: assert property (@(posedge rst) disable iff (clk)
		(load_a || load_b || load_m1 || load_m2) |-> (count_q != '0));

	// only the branch itself issues in its first shadow cycle
	a_no_issue_in_delay: assert property (@(posedge rst) disable iff (clk)
		(state_q == SEQ_DELAY && $past(state_q) == SEQ_DELAY) |-> !issue_valid);

endmodule

// File: decode/operand_select.sv
`timescale 1ns/1ps

module operand_select import decoder_pkg::*; (
	input logic rst, // clock
	input logic clk, // async reset
	input word_t word,
	input word_t r1,
	input word_t r2,
	input logic decode_en,
	input logic load_a,
	input logic load_b,
	input logic load_m1,
	input logic load_m2,
	input logic issue_valid,
	input logic a_from_file,
	input logic b_from_file,
	input logic m1_from_file,
	input logic force_b_one,
	output word_t e_a,
	output word_t e_b,
	output word_t m_a1,
	output word_t m_a2
);

	logic a_file_q, b_file_q, m1_file_q; // operand comes from register file
	logic force_q;
	word_t imm_a, imm_b, imm_m1, imm_m2;

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			a_file_q <= 1'b0;
			b_file_q <= 1'b0;
			m1_file_q <= 1'b0;
			force_q <= 1'b0;
		end else if (decode_en) begin
			a_file_q <= a_from_file;
			b_file_q <= b_from_file;
			m1_file_q <= m1_from_file;
			force_q <= force_b_one;
		end else begin
			if (load_a)
				a_file_q <= 1'b0; // immediate overrides file
			if (load_b)
				b_file_q <= 1'b0;
			if (load_m1)
				m1_file_q <= 1'b0;
		end
	end

	always_ff @(posedge rst) begin
		if (decode_en) begin
			imm_a <= '0; // unused slots read as zero
			imm_b <= '0;
			imm_m1 <= '0;
			imm_m2 <= '0;
		end else begin
			if (load_a)
				imm_a <= word;
			if (load_b)
				imm_b <= word;
			if (load_m1)
				imm_m1 <= word;
			if (load_m2)
				imm_m2 <= word;
		end
	end

	assign e_a = !issue_valid ? '0 : a_file_q ? r1 : imm_a;
	assign e_b = !issue_valid ? '0 : force_q ? word_t'(1) : b_file_q ? r2 : imm_b; // inc, dec
	assign m_a1 = !issue_valid ? '0 : m1_file_q ? r1 : imm_m1;
	assign m_a2 = issue_valid ? imm_m2 : '0; // immediate only

	// one immediate word per cycle
	a_one_load: assert property (@(posedge rst) disable iff (clk)
		$onehot0({load_a, load_b, load_m1, load_m2}));

endmodule

// File: source/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder import decoder_pkg::*; (
	input logic rst, // clock
	input logic clk, // async reset
	input word_t word, // insn or immediate from program memory
	input word_t r1, // register file answers, same cycle
	input word_t r2,
	output word_t e_a,
	output word_t e_b,
	output alu_op_e e_alu_op,
	output logic e_is_cond,
	output cond_t e_cond,
	output flags_t e_write_flags,
	output word_t m_a1,
	output word_t m_a2,
	output mem_op_e m_r1_op,
	output mem_op_e m_r2_op,
	output reg_addr_t r_a1,
	output reg_addr_t r_a2,
	output wb_op_e r_op,
	output reg_addr_t r_r1_addr,
	output reg_addr_t r_r2_addr,
	output read_mask_t r_read,
	output logic d_pcincr, // fetch request
	output logic issue_valid
);

	alu_op_e dec_alu_op;
	cond_t dec_cond;
	flags_t dec_flags;
	logic dec_is_cond;
	mem_op_e dec_m1_op, dec_m2_op;
	wb_op_e dec_wb_op;
	reg_addr_t dec_wb_a1, dec_wb_a2, dec_rd1, dec_rd2;
	read_mask_t dec_read;
	logic dec_a_file, dec_b_file, dec_m1_file, dec_force_b;
	imm_op_e dec_imm_op;
	logic dec_branch, dec_legal;
	logic decode_en;
	logic load_a, load_b, load_m1, load_m2;

	opcode_table u_table (
		.word(word), .alu_op(dec_alu_op), .cond(dec_cond), .write_flags(dec_flags),
		.is_cond(dec_is_cond), .m_r1_op(dec_m1_op), .m_r2_op(dec_m2_op),
		.r_op(dec_wb_op), .r_a1(dec_wb_a1), .r_a2(dec_wb_a2),
		.rd1_addr(dec_rd1), .rd2_addr(dec_rd2), .read_mask(dec_read),
		.a_from_file(dec_a_file), .b_from_file(dec_b_file), .m1_from_file(dec_m1_file),
		.force_b_one(dec_force_b), .imm_op(dec_imm_op), .is_branch(dec_branch),
		.legal(dec_legal)
	);

	issue_sequencer u_seq (
		.rst(rst), .clk(clk),
		.alu_op(dec_alu_op), .cond(dec_cond), .write_flags(dec_flags),
		.is_cond(dec_is_cond), .mem1_op(dec_m1_op), .mem2_op(dec_m2_op),
		.wb_op(dec_wb_op), .wb_a1(dec_wb_a1), .wb_a2(dec_wb_a2),
		.rd1_addr(dec_rd1), .rd2_addr(dec_rd2), .read_mask(dec_read),
		.imm_op(dec_imm_op), .is_branch(dec_branch), .legal(dec_legal),
		.e_alu_op(e_alu_op), .e_cond(e_cond), .e_write_flags(e_write_flags),
		.e_is_cond(e_is_cond), .m_r1_op(m_r1_op), .m_r2_op(m_r2_op),
		.r_op(r_op), .r_a1(r_a1), .r_a2(r_a2),
		.r_r1_addr(r_r1_addr), .r_r2_addr(r_r2_addr), .r_read(r_read),
		.issue_valid(issue_valid), .d_pcincr(d_pcincr), .decode_en(decode_en),
		.load_a(load_a), .load_b(load_b), .load_m1(load_m1), .load_m2(load_m2)
	);

	operand_select u_opsel (
		.rst(rst), .clk(clk), .word(word), .r1(r1), .r2(r2),
		.decode_en(decode_en), .load_a(load_a), .load_b(load_b),
		.load_m1(load_m1), .load_m2(load_m2), .issue_valid(issue_valid),
		.a_from_file(dec_a_file), .b_from_file(dec_b_file),
		.m1_from_file(dec_m1_file), .force_b_one(dec_force_b),
		.e_a(e_a), .e_b(e_b), .m_a1(m_a1), .m_a2(m_a2)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic rst, // clock, 10 ns period
	output logic clk // reset, active high
);

	initial begin
		rst = 1'b0;
		forever #5 rst = ~rst;
	end

	initial begin
		clk = 1'b1; // held for two rising edges
		repeat (2) @(posedge rst);
		@(negedge rst);
		clk = 1'b0;
	end

endmodule

// File: tests/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input logic rst, // clock
	input logic clk, // reset
	input logic issue_valid,
	input logic d_pcincr,
	input logic [7:0] e_alu_op,
	input logic [3:0] e_cond,
	input logic [3:0] e_write_flags,
	input logic e_is_cond,
	input logic [3:0] m_r1_op,
	input logic [3:0] m_r2_op,
	input logic [3:0] r_op,
	input logic [4:0] r_a1,
	input logic [4:0] r_a2,
	input logic [4:0] r_r1_addr,
	input logic [4:0] r_r2_addr,
	input logic [1:0] r_read,
	input logic [31:0] e_a,
	input logic [31:0] e_b,
	input logic [31:0] m_a1,
	input logic [31:0] m_a2,
	input logic exp_push, // expected bundle for a later issue
	input logic [178:0] exp_bundle,
	input logic row_valid, // a table row is on the word input
	input logic row_pcincr,
	input logic done,
	output int errors,
	output logic finished
);

	localparam int BW = 179;

	string fname [16] = '{"e_alu_op", "e_cond", "e_write_flags", "e_is_cond", "m_r1_op",
		"m_r2_op", "r_op", "r_a1", "r_a2", "r_r1_addr", "r_r2_addr", "r_read",
		"e_a", "e_b", "m_a1", "m_a2"};
	int fwidth [16] = '{8, 4, 4, 1, 4, 4, 4, 5, 5, 5, 5, 2, 32, 32, 32, 32};

	logic [BW-1:0] exp_q [$]; // bundles in issue order
	logic [BW-1:0] actual;
	logic [BW-1:0] expd;
	int value_errs;
	int proto_errs;
	int issues;
	int pushed;

	assign actual = {e_alu_op, e_cond, e_write_flags, e_is_cond, m_r1_op, m_r2_op, r_op,
		r_a1, r_a2, r_r1_addr, r_r2_addr, r_read, e_a, e_b, m_a1, m_a2};
	assign errors = value_errs + proto_errs;

	// field by field, msb field first
	task automatic compare(input logic [BW-1:0] e, input logic [BW-1:0] a);
		int pos;
		logic [BW-1:0] te;
		logic [BW-1:0] ta;
		logic [31:0] ev;
		logic [31:0] av;
		logic [31:0] mask;
		pos = BW;
		for (int i = 0; i < 16; i++) begin
			pos = pos - fwidth[i];
			mask = (32'd1 << fwidth[i]) - 32'd1; // wraps to all ones at 32
			te = e >> pos;
			ta = a >> pos;
			ev = te[31:0] & mask;
			av = ta[31:0] & mask;
			if (ev !== av) begin
				value_errs++;
				$display("MISMATCH t=%0t %s expected %h got %h", $time, fname[i], ev, av);
			end
		end
	endtask

	initial begin
		value_errs = 0;
		proto_errs = 0;
		issues = 0;
		pushed = 0;
		finished = 1'b0;
	end

	always @(posedge rst) begin
		if (clk) begin
			if (issue_valid || d_pcincr) begin
				proto_errs++;
				$display("t=%0t issue or fetch request active during reset", $time);
			end
			compare('0, actual);
		end else begin
			if (issue_valid) begin
				issues++;
				if (exp_q.size() == 0) begin
					proto_errs++;
					$display("t=%0t issue with no instruction expected", $time);
				end else begin
					expd = exp_q.pop_front();
					compare(expd, actual);
				end
			end else
				compare('0, actual); // bubble is all zero
			if (row_valid && d_pcincr !== row_pcincr) begin
				value_errs++;
				$display("MISMATCH t=%0t d_pcincr expected %b got %b", $time,
					row_pcincr, d_pcincr);
			end
			if (exp_push) begin
				exp_q.push_back(exp_bundle);
				pushed++;
			end
			if (done && !finished) begin
				if (issues != pushed || exp_q.size() != 0) begin
					proto_errs++;
					$display("issue count wrong, %0d issued of %0d expected", issues, pushed);
				end
				$display("checker: %0d value mismatches, %0d protocol errors, %0d of %0d issued",
					value_errs, proto_errs, issues, pushed);
				finished = 1'b1;
			end
		end
	end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ps

module tb_top import decoder_pkg::*; ();

	localparam int BW = 179;
	localparam logic [31:0] REG_OFS = 32'h4000_0100; // register file model offset
	localparam logic [31:0] IDLE_WORD = 32'hFE00_0000; // opcode 127, never issues

	logic rst, clk;
	logic [31:0] word, r1, r2;
	logic [7:0] e_alu_op;
	logic [3:0] e_cond, e_write_flags, m_r1_op, m_r2_op, r_op;
	logic e_is_cond, d_pcincr, issue_valid;
	logic [4:0] r_a1, r_a2, r_r1_addr, r_r2_addr;
	logic [1:0] r_read;
	logic [31:0] e_a, e_b, m_a1, m_a2;
	logic exp_push, row_valid, row_pcincr, done, finished, table_ready;
	logic [BW-1:0] exp_bundle;
	int errors;

	logic [31:0] word_q [$]; // stimulus table
	bit push_q [$];
	logic [BW-1:0] exp_q [$];
	bit pc_q [$];

	tb_clock clk0 (.rst(rst), .clk(clk));

	insn_decoder dut0 (
		.rst(rst), .clk(clk), .word(word), .r1(r1), .r2(r2),
		.e_a(e_a), .e_b(e_b), .e_alu_op(e_alu_op), .e_is_cond(e_is_cond),
		.e_cond(e_cond), .e_write_flags(e_write_flags), .m_a1(m_a1), .m_a2(m_a2),
		.m_r1_op(m_r1_op), .m_r2_op(m_r2_op), .r_a1(r_a1), .r_a2(r_a2), .r_op(r_op),
		.r_r1_addr(r_r1_addr), .r_r2_addr(r_r2_addr), .r_read(r_read),
		.d_pcincr(d_pcincr), .issue_valid(issue_valid)
	);

	tb_checker chk0 (
		.rst(rst), .clk(clk), .issue_valid(issue_valid), .d_pcincr(d_pcincr),
		.e_alu_op(e_alu_op), .e_cond(e_cond), .e_write_flags(e_write_flags),
		.e_is_cond(e_is_cond), .m_r1_op(m_r1_op), .m_r2_op(m_r2_op), .r_op(r_op),
		.r_a1(r_a1), .r_a2(r_a2), .r_r1_addr(r_r1_addr), .r_r2_addr(r_r2_addr),
		.r_read(r_read), .e_a(e_a), .e_b(e_b), .m_a1(m_a1), .m_a2(m_a2),
		.exp_push(exp_push), .exp_bundle(exp_bundle), .row_valid(row_valid),
		.row_pcincr(row_pcincr), .done(done), .errors(errors), .finished(finished)
	);

	function automatic logic [31:0] rf(input logic [4:0] r);
		rf = {27'd0, r} + REG_OFS; // what the register file returns
	endfunction

	assign r1 = rf(r_r1_addr);
	assign r2 = rf(r_r2_addr);

	function automatic logic [31:0] mk(input logic [6:0] op, input logic [3:0] cd,
		input logic [4:0] a, input logic [4:0] b, input logic [4:0] c, input logic [4:0] d);
		mk = {op, cd, a, b, c, d, 1'b0};
	endfunction

	function automatic logic [BW-1:0] bundle(input logic [7:0] alu, input logic [3:0] cd,
		input logic [3:0] fl, input logic isc, input logic [3:0] m1, input logic [3:0] m2,
		input logic [3:0] wb, input logic [4:0] wa1, input logic [4:0] wa2,
		input logic [4:0] rd1, input logic [4:0] rd2, input logic [1:0] rm,
		input logic [31:0] ea, input logic [31:0] eb, input logic [31:0] ma1,
		input logic [31:0] ma2);
		bundle = {alu, cd, fl, isc, m1, m2, wb, wa1, wa2, rd1, rd2, rm, ea, eb, ma1, ma2};
	endfunction

	task automatic add_row(input logic [31:0] w, input bit push, input logic [BW-1:0] e,
		input bit pc);
		word_q.push_back(w);
		push_q.push_back(push);
		exp_q.push_back(e);
		pc_q.push_back(pc);
	endtask

	// opcode word, then 0..2 immediates; only the last word carries the bundle
	task automatic add_insn(input logic [31:0] w, input logic [1:0] act,
		input logic [31:0] i1, input logic [31:0] i2, input logic [BW-1:0] e);
		add_row(w, act == 2'b00, e, 1'b1);
		if (act != 2'b00)
			add_row(i1, act != 2'b11, e, 1'b1);
		if (act == 2'b11)
			add_row(i2, 1'b1, e, 1'b1);
	endtask

	task automatic reg_alu(input logic [6:0] op, input logic [7:0] alu, input logic [3:0] wb);
		logic [3:0] cd;
		logic [4:0] a, b, c, d;
		cd = 4'($urandom);
		a = 5'($urandom);
		b = 5'($urandom);
		c = 5'($urandom);
		d = 5'($urandom) & 5'b00111; // keeps immediate bits clear
		add_insn(mk(op, cd, a, b, c, d), 2'b00, 32'd0, 32'd0,
			bundle(alu, cd, 4'hF, 1'b1, 4'h1, 4'h1, wb, (wb == 4'h0) ? 5'd0 : c,
			(wb == 4'h7) ? d : 5'd0, a, b, 2'b11, rf(a), rf(b), 32'd0, 32'd0));
	endtask

	task automatic inc_dec(input logic [6:0] op, input logic [7:0] alu);
		logic [3:0] cd;
		logic [4:0] a, c;
		cd = 4'($urandom);
		a = 5'($urandom);
		c = 5'($urandom);
		add_insn(mk(op, cd, a, 5'($urandom), c, 5'd0), 2'b00, 32'd0, 32'd0,
			bundle(alu, cd, 4'hF, 1'b1, 4'h1, 4'h1, 4'h1, c, 5'd0, a, 5'd0, 2'b01,
			rf(a), 32'd1, 32'd0, 32'd0));
	endtask

	task automatic imm_add(input logic [1:0] act);
		logic [3:0] cd;
		logic [4:0] a, b, c;
		logic [31:0] i1, i2, ea, eb;
		cd = 4'($urandom);
		a = 5'($urandom);
		b = 5'($urandom);
		c = 5'($urandom);
		i1 = $urandom;
		i2 = $urandom;
		ea = act[1] ? i1 : rf(a);
		eb = (act == 2'b01) ? i1 : (act == 2'b11) ? i2 : rf(b);
		add_insn(mk(OP_ADD, cd, a, b, c, {act, 3'b000}), act, i1, i2,
			bundle(8'h01, cd, 4'hF, 1'b1, 4'h1, 4'h1, 4'h1, c, 5'd0, a, b, 2'b11,
			ea, eb, 32'd0, 32'd0));
	endtask

	task automatic branch(input logic [6:0] op);
		logic [3:0] cd;
		logic [4:0] a;
		logic [BW-1:0] e;
		cd = 4'($urandom);
		a = 5'($urandom);
		case (op)
			OP_BR: e = bundle(8'h00, cd, 4'h0, 1'b1, 4'h1, 4'h1, 4'h1, 5'd31, 5'd0,
				a, 5'd0, 2'b01, rf(a), 32'd0, 32'd0, 32'd0);
			OP_RBR: e = bundle(8'h01, cd, 4'h0, 1'b1, 4'h1, 4'h1, 4'h1, 5'd31, 5'd0,
				5'd31, a, 2'b11, rf(5'd31), rf(a), 32'd0, 32'd0); // pc + a
			OP_BRL: e = bundle(8'h00, cd, 4'h0, 1'b1, 4'h1, 4'h1, 4'h7, 5'd31, 5'd29,
				a, 5'd31, 2'b11, rf(a), rf(5'd31), 32'd0, 32'd0); // old pc to lr
			default: e = bundle(8'h00, cd, 4'h0, 1'b1, 4'h1, 4'h1, 4'h1, 5'd31, 5'd0,
				5'd29, 5'd0, 2'b01, rf(5'd29), 32'd0, 32'd0, 32'd0); // ret
		endcase
		add_row(mk(op, cd, a, 5'($urandom), 5'($urandom), 5'd0), 1'b1, e, 1'b1);
		for (int i = 0; i < 3; i++) // shadow words would issue if decoded
			add_row(mk(OP_ADD, 4'($urandom), 5'($urandom), 5'($urandom), 5'($urandom),
				5'd0), 1'b0, '0, 1'b0);
	endtask

	task automatic mem_form(input logic [6:0] op, input logic [3:0] m1, input logic [3:0] m2,
		input logic load, input logic [1:0] act);
		logic [3:0] cd;
		logic [4:0] a, b, c;
		logic [31:0] i1, i2, ma1, ma2;
		cd = 4'($urandom);
		a = 5'($urandom);
		b = 5'($urandom);
		c = 5'($urandom);
		i1 = $urandom;
		i2 = $urandom;
		ma1 = (act == 2'b01) ? i1 : (act == 2'b11) ? i2 : rf(a);
		ma2 = act[1] ? i1 : 32'd0; // m_a2 takes the first word
		add_insn(mk(op, cd, a, b, c, {act, 3'b000}), act, i1, i2,
			bundle(8'h00, cd, 4'h0, 1'b1, m1, m2, load ? 4'h1 : 4'h0, load ? c : 5'd0,
			5'd0, a, load ? 5'd0 : b, load ? 2'b01 : 2'b11, 32'd0,
			load ? 32'd0 : rf(b), ma1, ma2));
	endtask

	task automatic build_table();
		add_row(mk(OP_NOP, 4'($urandom), 5'($urandom), 5'($urandom), 5'($urandom),
			5'($urandom)), 1'b1, '0, 1'b1);
		add_row({7'(35 + ($urandom % 93)), 25'($urandom)}, 1'b0, '0, 1'b1);
		reg_alu(OP_OR, 8'h0D, 4'h1);
		reg_alu(OP_NOR, 8'h10, 4'h1);
		reg_alu(OP_AND, 8'h0C, 4'h1);
		reg_alu(OP_NAND, 8'h0F, 4'h1);
		reg_alu(OP_XOR, 8'h0E, 4'h1);
		reg_alu(OP_XNOR, 8'h11, 4'h1);
		reg_alu(OP_LSL, 8'h06, 4'h1);
		reg_alu(OP_LSR, 8'h05, 4'h1);
		reg_alu(OP_ASR, 8'h07, 4'h1);
		reg_alu(OP_ASL, 8'h08, 4'h1);
		reg_alu(OP_CSR, 8'h09, 4'h1);
		reg_alu(OP_CSL, 8'h0A, 4'h1);
		reg_alu(OP_ADD, 8'h01, 4'h1);
		reg_alu(OP_SUB, 8'h02, 4'h1);
		reg_alu(OP_MULL, 8'h04, 4'h1);
		reg_alu(OP_MULH, 8'h04, 4'h4);
		reg_alu(OP_MUL, 8'h04, 4'h7);
		reg_alu(OP_CMP, 8'h02, 4'h0);
		reg_alu(OP_CMN, 8'h01, 4'h0);
		reg_alu(OP_TST, 8'h0C, 4'h0);
		inc_dec(OP_INC, 8'h01);
		inc_dec(OP_DEC, 8'h02);
		imm_add(2'b01);
		imm_add(2'b10);
		imm_add(2'b11);
		branch(OP_BR);
		reg_alu(OP_ADD, 8'h01, 4'h1);
		branch(OP_RBR);
		reg_alu(OP_XOR, 8'h0E, 4'h1);
		branch(OP_BRL);
		branch(OP_RET); // back to back branches
		reg_alu(OP_SUB, 8'h02, 4'h1);
		mem_form(OP_LDR, 4'h2, 4'h1, 1'b1, 2'b00);
		mem_form(OP_LDR, 4'h2, 4'h1, 1'b1, 2'b10);
		mem_form(OP_IN, 4'h8, 4'h1, 1'b1, 2'b00);
		mem_form(OP_STR, 4'h1, 4'h5, 1'b0, 2'b00);
		mem_form(OP_STR, 4'h1, 4'h5, 1'b0, 2'b01);
		mem_form(OP_STR, 4'h1, 4'h5, 1'b0, 2'b10);
		mem_form(OP_STR, 4'h1, 4'h5, 1'b0, 2'b11);
		mem_form(OP_OUT, 4'h1, 4'hB, 1'b0, 2'b00);
		add_row({7'(35 + ($urandom % 93)), 25'($urandom)}, 1'b0, '0, 1'b1);
		add_row(32'd0, 1'b1, '0, 1'b1);
	endtask

	initial begin
		word = IDLE_WORD;
		exp_push = 1'b0;
		exp_bundle = '0;
		row_valid = 1'b0;
		row_pcincr = 1'b0;
		done = 1'b0;
		table_ready = 1'b0;
		void'($urandom(32'hc4e0_b65f));
		build_table();
		table_ready = 1'b1;
		@(negedge clk); // reset released
		for (int i = 0; i < word_q.size(); i++) begin
			@(negedge rst);
			word = word_q[i];
			exp_push = push_q[i];
			exp_bundle = exp_q[i];
			row_pcincr = pc_q[i];
			row_valid = 1'b1;
		end
		@(negedge rst);
		word = IDLE_WORD;
		exp_push = 1'b0;
		row_valid = 1'b0;
		repeat (5) @(negedge rst); // drain the last issue
		done = 1'b1;
		wait (finished);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// table length plus 20 cycles
	initial begin
		wait (table_ready);
		#((word_q.size() + 20) * 10);
		$display("watchdog expired, the run did not finish in time");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+common
common/decoder_pkg.sv
decode/opcode_table.sv
decode/issue_sequencer.sv
decode/operand_select.sv
source/insn_decoder.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_MSG ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
